// File: sim.f
+incdir+.
muldiv_pkg.sv
div_special.sv
div_ctrl.sv
div_datapath.sv
muldiv_top.sv
tb_clkgen.sv
muldiv_assert.sv
muldiv_tb.sv

// File: Makefile
TOP := muldiv_tb
LOG := sim.log

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failures found" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "All tests passed!" $(LOG)

obj_dir/V$(TOP): sim.f $(wildcard *.sv *.svh)
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -Wall -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// File: muldiv_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "muldiv_cfg.svh"

module muldiv_tb;
  import muldiv_pkg::*;

  localparam int XW = `MDV_XLEN;

  // one stimulus row plus what the model expects back
  typedef struct {
    string         name;
    div_op_e       op;
    logic [XW-1:0] rs1;
    logic [XW-1:0] rs2;
    logic          b2b;
    int            flush_at;
    int            bp;
    logic [XW-1:0] exp;
    logic          instant;
  } test_row_t;

  logic          clk;
  logic          rst_n;
  logic          i_valid;
  div_req_t      i_req;
  logic          i_flush;
  logic          o_ready;
  logic          i_ready;
  logic          o_valid;
  logic [XW-1:0] o_wdat;

  test_row_t rows[$];
  int        seed = 32'hfc1e;
  int        cycle_cnt = 0;
  int        cycle_limit = 0;
  int        row_errs = 0;
  int        n_pass = 0;
  int        n_fail = 0;
  // a flushed division leaves the stored quot/remd unusable
  logic      flush_pending = 1'b0;

  tb_clkgen tb_clkgen_i (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  muldiv_top muldiv_top_i (
    .clk     (clk),
    .i_rst_n (rst_n),
    .i_valid (i_valid),
    .i_req   (i_req),
    .i_flush (i_flush),
    .o_ready (o_ready),
    .i_ready (i_ready),
    .o_valid (o_valid),
    .o_wdat  (o_wdat)
  );

  bind muldiv_top muldiv_assert muldiv_assert_i (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_in_valid  (i_valid),
    .i_in_ready  (i_ready),
    .i_out_valid (o_valid),
    .i_out_ready (o_ready),
    .i_flush     (i_flush),
    .i_wdat      (o_wdat),
    .i_state     (div_ctrl_i.state_r)
  );

  //////////////////////////////////////////////////
  // reference model, RISC-V M rules

  function automatic logic [XW-1:0] model_div(div_op_e op, logic [XW-1:0] a, logic [XW-1:0] b);
    logic signed [XW-1:0] sa;
    logic signed [XW-1:0] sb;
    logic                 is_quot;
    logic                 is_sgn;
    logic [XW-1:0]        res;
    sa      = a;
    sb      = b;
    is_quot = (op == OP_DIV) || (op == OP_DIVU);
    is_sgn  = (op == OP_DIV) || (op == OP_REM);
    if (b == '0) begin
      // x/0 is all ones, x%0 is x
      res = is_quot ? '1 : a;
    end else if (is_sgn && a == {1'b1, {(XW-1){1'b0}}} && b == '1) begin
      res = is_quot ? a : '0;
    end else begin
      // sv division truncates toward zero like RISC-V
      case (op)
        OP_DIV:  res = sa / sb;
        OP_REM:  res = sa % sb;
        OP_DIVU: res = a / b;
        default: res = a % b;
      endcase
    end
    return res;
  endfunction

  //////////////////////////////////////////////////
  // test table

  task automatic add_row(input string name, input div_op_e op, input logic [XW-1:0] a,
                         input logic [XW-1:0] b, input logic b2b, input int flush_at,
                         input int bp);
    test_row_t r;
    logic      special;
    special    = (b == '0) || (((op == OP_DIV) || (op == OP_REM))
                 && a == {1'b1, {(XW-1){1'b0}}} && b == '1);
    r.name     = name;
    r.op       = op;
    r.rs1      = a;
    r.rs2      = b;
    r.b2b      = b2b;
    r.flush_at = flush_at;
    r.bp       = bp;
    r.exp      = model_div(op, a, b);
    r.instant  = 1'b0;
    if (flush_at == 0) begin
      // same-cycle answer for special cases and clean b2b reuse
      r.instant     = special || (b2b && !flush_pending);
      flush_pending = 1'b0;
    end else begin
      flush_pending = 1'b1;
    end
    rows.push_back(r);
  endtask

  task automatic build_table();
    int            k;
    logic [XW-1:0] a;
    logic [XW-1:0] b;
    logic [XW-1:0] r;
    add_row("div_basic",       OP_DIV,  32'd1000,       32'd7,        1'b0, 0, 0);
    add_row("rem_b2b",         OP_REM,  32'd1000,       32'd7,        1'b1, 0, 0);
    add_row("divu_big",        OP_DIVU, 32'hffff_fff0,  32'd3,        1'b0, 0, 0);
    add_row("remu_b2b",        OP_REMU, 32'hffff_fff0,  32'd3,        1'b1, 0, 0);
    add_row("div_neg_both",    OP_DIV,  -32'd77,        -32'd5,       1'b0, 0, 0);
    add_row("rem_neg_num",     OP_REM,  -32'd77,        32'd5,        1'b0, 0, 0);
    add_row("div_b2b",         OP_DIV,  -32'd77,        32'd5,        1'b1, 0, 0);
    add_row("div_exact_neg",   OP_DIV,  -32'd20,        32'd5,        1'b0, 0, 0);
    add_row("rem_exact",       OP_REM,  32'd20,         -32'd5,       1'b0, 0, 0);
    add_row("rem_neg_divs",    OP_REM,  32'd7,          -32'd7,       1'b0, 0, 0);
    add_row("divu_small",      OP_DIVU, 32'd3,          32'd10,       1'b0, 0, 0);
    add_row("remu_small",      OP_REMU, 32'd3,          32'd10,       1'b0, 0, 0);
    add_row("div_minneg_2",    OP_DIV,  32'h8000_0000,  32'd2,        1'b0, 0, 0);
    add_row("div_maxpos_self", OP_DIV,  32'h7fff_ffff,  32'h7fff_ffff, 1'b0, 0, 0);
    add_row("divu_by1",        OP_DIVU, 32'hdead_beef,  32'd1,        1'b0, 0, 0);
    // special cases
    add_row("div_by0",         OP_DIV,  32'h0000_1234,  32'd0,        1'b0, 0, 0);
    add_row("divu_by0",        OP_DIVU, 32'h8765_4321,  32'd0,        1'b0, 0, 0);
    add_row("rem_by0",         OP_REM,  32'h0000_1234,  32'd0,        1'b0, 0, 0);
    add_row("remu_by0",        OP_REMU, 32'h0000_cafe,  32'd0,        1'b0, 0, 0);
    add_row("div_ovf",         OP_DIV,  32'h8000_0000,  32'hffff_ffff, 1'b0, 0, 0);
    add_row("rem_ovf",         OP_REM,  32'h8000_0000,  32'hffff_ffff, 1'b0, 0, 0);
    add_row("divu_no_ovf",     OP_DIVU, 32'h8000_0000,  32'hffff_ffff, 1'b0, 0, 0);
    // flush mid EXEC, then a b2b mark that must not hit
    add_row("flush_exec",      OP_DIV,  32'd12345,      32'd67,       1'b0, 10, 0);
    add_row("div_after_flush", OP_DIV,  32'd12345,      32'd67,       1'b1, 0, 0);
    // consumer back-pressure
    add_row("rem_bp",          OP_REM,  -32'd1000,      32'd33,       1'b0, 0, 4);
    add_row("divu_bp",         OP_DIVU, 32'hffff_ffff,  32'h10,       1'b0, 0, 3);
    for (k = 0; k < 12; k++) begin
      a = $random(seed);
      b = $random(seed);
      r = $random(seed);
      // every third divisor kept small so quotients get wide
      if (k % 3 == 0) begin
        b = {{16{b[15]}}, b[15:0]};
      end
      add_row($sformatf("rand_%0d", k), div_op_e'(r[1:0]), a, b, 1'b0, 0, 0);
    end
  endtask

  //////////////////////////////////////////////////
  // compare tasks

  task automatic check_wdat(input string name, input logic [XW-1:0] exp,
                            input logic [XW-1:0] act);
    if (act !== exp) begin
      row_errs++;
      $display("FAILED %s wdat expected %h actual %h", name, exp, act);
    end
  endtask

  // lo/hi are the only two legal cycle counts
  task automatic check_latency(input string name, input int lo, input int hi, input int act);
    if (act != lo && act != hi) begin
      row_errs++;
      if (lo == hi) begin
        $display("FAILED %s latency expected %0d actual %0d", name, lo, act);
      end else begin
        $display("FAILED %s latency expected %0d or %0d actual %0d", name, lo, hi, act);
      end
    end
  endtask

  //////////////////////////////////////////////////
  // driver

  task automatic run_row(input test_row_t r);
    div_req_t      req;
    int            lat;
    int            k;
    logic [XW-1:0] got;
    req.rs1  = r.rs1;
    req.rs2  = r.rs2;
    req.op   = r.op;
    req.b2b  = r.b2b;
    lat      = 0;
    row_errs = 0;
    @(posedge clk);
    i_req   <= req;
    i_valid <= 1'b1;
    i_flush <= 1'b0;
    o_ready <= (r.bp == 0);
    @(negedge clk);
    if (r.flush_at != 0) begin
      while (lat < r.flush_at) begin
        if (o_valid) begin
          row_errs++;
          $display("%s: result offered before the flush point", r.name);
        end
        lat++;
        @(negedge clk);
      end
      // one-cycle flush pulse, issuer drops the request
      @(posedge clk);
      i_valid <= 1'b0;
      i_flush <= 1'b1;
    end else begin
      while (!o_valid) begin
        lat++;
        @(negedge clk);
      end
      got = o_wdat;
      for (k = 0; k < r.bp; k++) begin
        @(negedge clk);
        if (!o_valid || o_wdat !== got) begin
          row_errs++;
          $display("%s: result dropped or changed while o_ready was low", r.name);
        end
      end
      if (r.bp != 0) begin
        @(posedge clk);
        o_ready <= 1'b1;
        @(negedge clk);
      end
      if (!i_ready) begin
        row_errs++;
        $display("%s: i_ready low while the result is offered", r.name);
      end
      check_wdat(r.name, r.exp, o_wdat);
      if (r.instant) begin
        check_latency(r.name, 0, 0, lat);
      end else begin
        check_latency(r.name, `MDV_ITER + 1, `MDV_ITER + 3, lat);
      end
    end
    if (row_errs == 0) begin
      n_pass++;
      $display("ok   %-16s wdat=%h lat=%0d", r.name, o_wdat, lat);
    end else begin
      n_fail++;
      $display("bad  %-16s %0d error(s)", r.name, row_errs);
    end
  endtask

  // watchdog, limit set once the table is built
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout after %0d cycles, DUT never delivered a result", cycle_cnt);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    i_valid <= 1'b0;
    i_req   <= '0;
    i_flush <= 1'b0;
    o_ready <= 1'b0;
    build_table();
    foreach (rows[i]) begin
      cycle_limit += 40 + rows[i].bp + rows[i].flush_at;
    end
    // room for reset and the drain at the end
    cycle_limit += 10;
    wait (rst_n === 1'b1);
    foreach (rows[i]) begin
      run_row(rows[i]);
    end
    @(posedge clk);
    i_valid <= 1'b0;
    o_ready <= 1'b0;
    @(posedge clk);
    $display("tests %0d, passed %0d, failed %0d", rows.size(), n_pass, n_fail);
    if (n_fail == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: muldiv_assert.sv
`timescale 1ns/100ps
`default_nettype none

`include "muldiv_cfg.svh"

module muldiv_assert (
  input wire                         clk,
  input wire                         i_rst_n,
  input wire                         i_in_valid,
  input wire                         i_in_ready,
  input wire                         i_out_valid,
  input wire                         i_out_ready,
  input wire                         i_flush,
  input wire [`MDV_XLEN-1:0]         i_wdat,
  input wire muldiv_pkg::div_state_e i_state
);
  import muldiv_pkg::*;

  // a running division only offers its result from the check or correction states
  a_out_valid_state: assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_out_valid && i_state != ST_IDLE) |-> (i_state inside {ST_REMD_CHCK, ST_REMD_CORR}))
    else $error("o_valid high in a state that holds no result");

  // flush returns the FSM to idle on the next edge
  a_flush_to_idle: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_flush |=> (i_state == ST_IDLE))
    else $error("divider FSM not idle after a flush");

  // FSM never leaves its five encodings
  a_state_legal: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_state inside {ST_IDLE, ST_EXEC, ST_REMD_CHCK, ST_QUOT_CORR, ST_REMD_CORR})
    else $error("divider FSM in an illegal state");

  // back-pressure holds the result in place
  a_wdat_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_out_valid && !i_out_ready && !i_flush) |=> (i_out_valid && $stable(i_wdat)))
    else $error("o_wdat or o_valid changed while o_ready was low");

endmodule

`default_nettype wire

// File: tb_clkgen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen (
  output logic o_clk,
  output logic o_rst_n
);

  // free running clock, 20 ns period
  initial begin
    o_clk = 1'b0;
    forever begin
      #10 o_clk = ~o_clk;
    end
  end

  // sync reset, low for the first 3 rising edges
  initial begin
    o_rst_n <= 1'b0;
    repeat (3) @(posedge o_clk);
    o_rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// File: muldiv_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "muldiv_cfg.svh"

module muldiv_top (
  input  wire                       clk,
  input  wire                       i_rst_n,
  input  wire                       i_valid,
  input  wire muldiv_pkg::div_req_t i_req,
  input  wire                       i_flush,
  input  wire                       o_ready,
  output logic                      i_ready,
  output logic                      o_valid,
  output logic [`MDV_XLEN-1:0]      o_wdat
);
  import muldiv_pkg::*;

  div_step_t            step;
  logic                 need_corr;
  logic                 b2b_hit;
  logic                 res_ready;
  logic                 special;
  logic                 sel_quot;
  logic [`MDV_XLEN-1:0] special_res;
  logic [`MDV_XLEN-1:0] quot;
  logic [`MDV_XLEN-1:0] remd;
  logic [`MDV_XLEN-1:0] quot_r;
  logic [`MDV_XLEN-1:0] remd_r;

  div_special div_special_i (
    .i_req         (i_req),
    .o_special     (special),
    .o_special_res (special_res)
  );

  div_ctrl div_ctrl_i (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_valid     (i_valid),
    .i_flush     (i_flush),
    .i_ready_out (o_ready),
    .i_op        (i_req.op),
    .i_b2b       (i_req.b2b),
    .i_special   (special),
    .i_need_corr (need_corr),
    .o_step      (step),
    .o_b2b_hit   (b2b_hit),
    .o_res_ready (res_ready)
  );

  div_datapath div_datapath_i (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_req       (i_req),
    .i_step      (step),
    .o_need_corr (need_corr),
    .o_quot      (quot),
    .o_remd      (remd),
    .o_quot_r    (quot_r),
    .o_remd_r    (remd_r)
  );

  //////////////////////////////////////////////////
  // write-back

  // issuer holds i_valid, so both sides just wait for the result
  assign o_valid = i_valid & res_ready;
  assign i_ready = o_ready & res_ready;

  assign sel_quot = (i_req.op == OP_DIV) || (i_req.op == OP_DIVU);

  // special first, then stored b2b value, then the live divider
  assign o_wdat = special ? special_res
                : b2b_hit ? (sel_quot ? quot_r : remd_r)
                : (sel_quot ? quot : remd);

endmodule

`default_nettype wire

// File: div_datapath.sv
`timescale 1ns/100ps
`default_nettype none

`include "muldiv_cfg.svh"

module div_datapath (
  input  wire                        clk,
  input  wire                        i_rst_n,
  input  wire muldiv_pkg::div_req_t  i_req,
  input  wire muldiv_pkg::div_step_t i_step,
  output logic                       o_need_corr,
  output logic [`MDV_XLEN-1:0]       o_quot,
  output logic [`MDV_XLEN-1:0]       o_remd,
  output logic [`MDV_XLEN-1:0]       o_quot_r,
  output logic [`MDV_XLEN-1:0]       o_remd_r
);
  import muldiv_pkg::*;

  localparam int XW = `MDV_XLEN;
  localparam int AW = `MDV_ADDER_W;
  // partial register width, operand plus sign
  localparam int RW = `MDV_XLEN + 1;

  logic          rs1_sgn;
  logic          rs2_sgn;
  logic [AW-1:0] divisor;
  logic          quot0;
  logic          prev_quot;
  adder_req_t    add_req;
  logic [AW-1:0] add_res;
  logic          cur_quot;
  logic [RW-1:0] exe_low;
  logic [RW-1:0] exe_remd_sh;
  logic [RW-1:0] exe_quot_sh;
  logic [RW-1:0] div_remd;
  logic [RW-1:0] div_quot;
  logic [RW-1:0] part_remd_r;
  logic [RW-1:0] part_quot_r;
  logic          remd_sft1_r;
  logic          remd_fix_r;
  logic          step_adv;
  logic          remd_wr;
  logic          remd_is_0;
  logic          remd_is_neg_divs;
  logic          remd_is_divs;
  logic          remd_inc_quot_dec;

  //////////////////////////////////////////////////
  // operands

  // unsigned ops see a zero sign bit
  assign rs1_sgn = (i_req.op == OP_DIV) || (i_req.op == OP_REM) ? i_req.rs1[XW-1] : 1'b0;
  assign rs2_sgn = (i_req.op == OP_DIV) || (i_req.op == OP_REM) ? i_req.rs2[XW-1] : 1'b0;
  assign divisor = {rs2_sgn, rs2_sgn, i_req.rs2};

  // first quotient digit: -1 when signs differ
  assign quot0     = ~(rs1_sgn ^ rs2_sgn);
  assign prev_quot = i_step.first ? quot0 : part_quot_r[0];

  //////////////////////////////////////////////////
  // adder operation per state

  assign remd_inc_quot_dec = part_remd_r[RW-1] ^ divisor[AW-1];

  always_comb begin
    add_req = '0;
    if (i_step.first || i_step.iter) begin
      // non-restoring step, subtract after a 1 digit, add after -1
      add_req.op1 = i_step.first ? {AW{rs1_sgn}} : {remd_sft1_r, part_remd_r};
      add_req.op2 = divisor;
      add_req.sub = prev_quot;
    end else if (i_step.chck) begin
      // remd + divisor, zero means remd == -divisor
      add_req.op1 = {part_remd_r[RW-1], part_remd_r};
      add_req.op2 = divisor;
      add_req.sub = 1'b0;
    end else if (i_step.quot_corr) begin
      add_req.op1 = {part_quot_r[RW-1], part_quot_r};
      add_req.op2 = AW'(1);
      add_req.sub = remd_inc_quot_dec;
    end else if (i_step.remd_corr) begin
      add_req.op1 = {part_remd_r[RW-1], part_remd_r};
      add_req.op2 = divisor;
      add_req.sub = ~remd_inc_quot_dec;
    end
  end

  assign add_res = add_req.op1 + (add_req.op2 ^ {AW{add_req.sub}}) + AW'(add_req.sub);

  // next digit from the sign of the new partial remainder
  assign cur_quot = ~(add_res[AW-1] ^ divisor[AW-1]);

  // low half of the shift pair, dividend bits then quotient digits
  assign exe_low     = i_step.first ? {i_req.rs1, quot0} : part_quot_r;
  assign exe_remd_sh = {add_res[XW-1:0], exe_low[RW-1]};
  assign exe_quot_sh = {exe_low[XW-1:0], cur_quot};

  //////////////////////////////////////////////////
  // results

  // remd is taken unshifted on the last step, quot lsb forced to 1
  // remd correction is combinational on the first REMD_CORR cycle
  assign div_remd = (i_step.chck || remd_fix_r) ? part_remd_r : add_res[RW-1:0];
  assign div_quot = (i_step.chck || i_step.quot_corr || i_step.remd_corr)
                  ? part_quot_r : {exe_low[XW-1:0], 1'b1};

  assign remd_is_0        = ~|part_remd_r;
  assign remd_is_neg_divs = ~|add_res;
  assign remd_is_divs     = (part_remd_r == divisor[RW-1:0]);

  // correction when remd sign is off, or remd is +/- divisor
  assign o_need_corr = i_step.chck & (((part_remd_r[RW-1] ^ rs1_sgn) & ~remd_is_0)
                                      | remd_is_neg_divs | remd_is_divs);

  //////////////////////////////////////////////////
  // partial remainder / quotient

  assign step_adv = i_step.first | (i_step.iter & ~i_step.last);
  // corrected remd written once, stays put under back-pressure
  assign remd_wr  = i_step.remd_corr & ~remd_fix_r;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      part_remd_r <= '0;
      part_quot_r <= '0;
      remd_sft1_r <= 1'b0;
      remd_fix_r  <= 1'b0;
    end else begin
      if (step_adv) begin
        part_remd_r <= exe_remd_sh;
      end else if (i_step.last || remd_wr) begin
        part_remd_r <= add_res[RW-1:0];
      end
      if (step_adv) begin
        part_quot_r <= exe_quot_sh;
      end else if (i_step.last) begin
        part_quot_r <= div_quot;
      end else if (i_step.quot_corr) begin
        part_quot_r <= add_res[RW-1:0];
      end
      // adder bit 32 that drops out of the 33-bit register on the shift
      if (i_step.first || i_step.iter) begin
        remd_sft1_r <= add_res[RW-1];
      end
      remd_fix_r <= i_step.remd_corr;
    end
  end

  assign o_quot   = div_quot[XW-1:0];
  assign o_remd   = div_remd[XW-1:0];
  assign o_quot_r = part_quot_r[XW-1:0];
  assign o_remd_r = part_remd_r[XW-1:0];

endmodule

`default_nettype wire

// File: div_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "muldiv_cfg.svh"

module div_ctrl (
  input  wire                        clk,
  input  wire                        i_rst_n,
  input  wire                        i_valid,
  input  wire                        i_flush,
  input  wire                        i_ready_out,
  input  wire muldiv_pkg::div_op_e   i_op,
  input  wire                        i_b2b,
  input  wire                        i_special,
  input  wire                        i_need_corr,
  output muldiv_pkg::div_step_t      o_step,
  output logic                       o_b2b_hit,
  output logic                       o_res_ready
);
  import muldiv_pkg::*;

  div_state_e            state_r;
  div_state_e            state_nxt;
  logic [`MDV_CNT_W-1:0] cnt_r;
  logic                  flushed_r;
  logic                  sta_idle;
  logic                  sta_exec;
  logic                  sta_chck;
  logic                  sta_quot_corr;
  logic                  sta_remd_corr;
  logic                  start;
  logic                  last;
  logic                  out_hsk;

  //////////////////////////////////////////////////
  // request classification

  // stored quot/remd only reusable if no flush since the last result
  assign o_b2b_hit = i_b2b & ~flushed_r;

  assign sta_idle      = (state_r == ST_IDLE);
  assign sta_exec      = (state_r == ST_EXEC);
  assign sta_chck      = (state_r == ST_REMD_CHCK);
  assign sta_quot_corr = (state_r == ST_QUOT_CORR);
  assign sta_remd_corr = (state_r == ST_REMD_CORR);

  // a real division starts from idle, special and b2b ones never leave it
  assign start = sta_idle & i_valid & ~i_special & ~o_b2b_hit & ~i_flush;
  assign last  = sta_exec & (cnt_r == `MDV_CNT_W'(`MDV_ITER));

  // result available this cycle
  assign o_res_ready = i_special | o_b2b_hit | (sta_chck & ~i_need_corr) | sta_remd_corr;
  assign out_hsk     = i_valid & i_ready_out & o_res_ready;

  //////////////////////////////////////////////////
  // FSM

  always_comb begin
    state_nxt = state_r;
    case (state_r)
      ST_IDLE: begin
        if (start) begin
          state_nxt = ST_EXEC;
        end
      end
      ST_EXEC: begin
        if (last) begin
          state_nxt = ST_REMD_CHCK;
        end
      end
      ST_REMD_CHCK: begin
        // hold here under back-pressure
        if (i_need_corr) begin
          state_nxt = ST_QUOT_CORR;
        end else if (out_hsk) begin
          state_nxt = ST_IDLE;
        end
      end
      ST_QUOT_CORR: state_nxt = ST_REMD_CORR;
      ST_REMD_CORR: begin
        if (out_hsk) begin
          state_nxt = ST_IDLE;
        end
      end
      default: state_nxt = ST_IDLE;
    endcase
    // flush wins from any state
    if (i_flush) begin
      state_nxt = ST_IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state_r   <= ST_IDLE;
      cnt_r     <= '0;
      flushed_r <= 1'b0;
    end else begin
      state_r <= state_nxt;
      // counter is 1 on the first EXEC cycle, idle step counts as step 0
      if (start) begin
        cnt_r <= `MDV_CNT_W'(1);
      end else if (sta_exec && !last) begin
        cnt_r <= cnt_r + 1'b1;
      end
      if (i_flush) begin
        flushed_r <= 1'b1;
      end else if (out_hsk) begin
        flushed_r <= 1'b0;
      end
    end
  end

  // strobes to datapath
  assign o_step.first     = start;
  assign o_step.iter      = sta_exec;
  assign o_step.last      = last;
  assign o_step.chck      = sta_chck;
  assign o_step.quot_corr = sta_quot_corr;
  assign o_step.remd_corr = sta_remd_corr;

endmodule

`default_nettype wire

// File: div_special.sv
`timescale 1ns/100ps
`default_nettype none

`include "muldiv_cfg.svh"

module div_special (
  input  wire muldiv_pkg::div_req_t i_req,
  output logic                      o_special,
  output logic [`MDV_XLEN-1:0]      o_special_res
);
  import muldiv_pkg::*;

  localparam int XW = `MDV_XLEN;

  logic          is_quot_op;
  logic          div_by_0;
  logic          div_ovf;
  logic [XW-1:0] by0_res;
  logic [XW-1:0] ovf_res;

  assign is_quot_op = (i_req.op == OP_DIV) || (i_req.op == OP_DIVU);

  // divisor all zeros
  assign div_by_0 = ~|i_req.rs2;

  // signed only, most negative dividend over -1
  assign div_ovf = ((i_req.op == OP_DIV) || (i_req.op == OP_REM))
                 & (&i_req.rs2)
                 & i_req.rs1[XW-1]
                 & ~|i_req.rs1[XW-2:0];

  // x/0 gives all ones, x%0 gives x
  assign by0_res = is_quot_op ? {XW{1'b1}} : i_req.rs1;

  // quotient wraps to the dividend, remainder is 0
  assign ovf_res = is_quot_op ? {1'b1, {(XW-1){1'b0}}} : '0;

  assign o_special     = div_by_0 | div_ovf;
  assign o_special_res = div_by_0 ? by0_res : ovf_res;

endmodule

`default_nettype wire

// File: muldiv_pkg.sv
`default_nettype none

`include "muldiv_cfg.svh"

package muldiv_pkg;

  // divide opcodes as seen from the decoder
  typedef enum logic [1:0] {
    OP_DIV  = 2'd0,
    OP_DIVU = 2'd1,
    OP_REM  = 2'd2,
    OP_REMU = 2'd3
  } div_op_e;

  // divider FSM states
  typedef enum logic [2:0] {
    ST_IDLE      = 3'd0,
    ST_EXEC      = 3'd1,
    ST_REMD_CHCK = 3'd2,
    ST_QUOT_CORR = 3'd3,
    ST_REMD_CORR = 3'd4
  } div_state_e;

  // issued request, b2b is the decoder's back-to-back mark
  typedef struct packed {
    logic [`MDV_XLEN-1:0] rs1;
    logic [`MDV_XLEN-1:0] rs2;
    div_op_e              op;
    logic                 b2b;
  } div_req_t;

  // one operation on the shared 34-bit adder
  typedef struct packed {
    logic [`MDV_ADDER_W-1:0] op1;
    logic [`MDV_ADDER_W-1:0] op2;
    logic                    sub;
  } adder_req_t;

  // per-cycle strobes, FSM to datapath
  typedef struct packed {
    logic first;
    logic iter;
    logic last;
    logic chck;
    logic quot_corr;
    logic remd_corr;
  } div_step_t;

endpackage

`default_nettype wire

// File: muldiv_cfg.svh
`ifndef MULDIV_CFG_SVH
`define MULDIV_CFG_SVH

// width of operands and of the write-back result
`define MDV_XLEN 32

// divider adder width
// operand plus two sign bits
`define MDV_ADDER_W 34

// number of EXEC cycles per division
// the idle cycle does one more step on its own
`define MDV_ITER 32

// iteration counter, wide enough to hold MDV_ITER
`define MDV_CNT_W 6

`endif
